// ==== hdl/atr_gpio.sv ====
////////////////////////////////////////////////////////////
// Automatic transmit/receive GPIO. Picks one of four pin words
// from the radio state and gates the outgoing sample.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "radio_ctrl_consts.svh"

module atr_gpio import radio_ctrl_pkg::*; (
   input  logic        dsp_clk,
   input  logic        por_rst,
   input  logic        set_stb_i,
   input  set_addr_t   set_addr_i,
   input  set_data_t   set_data_i,
   input  logic        run_rx_i,
   input  sample_t     sample_tx_i,
   input  logic [31:0] gpio_i,
   output sample_t     sample_tx_o,
   output logic        rx_active_o,
   output logic [31:0] gpio_o,
   output logic [31:0] gpio_rb_o
);

   set_data_t atr_idle;
   set_data_t atr_rx;
   set_data_t atr_tx;
   set_data_t atr_fdx;
   logic      tx_active;

   ////////////////////////////////////////////////////////////
   // One ATR word register per state

   setting_reg #(.addr(`SR_ATR_IDLE), .payload_t(set_data_t)) sr_atr_idle (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (atr_idle),
      .changed_o  ()
   );

   setting_reg #(.addr(`SR_ATR_RX), .payload_t(set_data_t)) sr_atr_rx (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (atr_rx),
      .changed_o  ()
   );

   setting_reg #(.addr(`SR_ATR_TX), .payload_t(set_data_t)) sr_atr_tx (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (atr_tx),
      .changed_o  ()
   );

   setting_reg #(.addr(`SR_ATR_FDX), .payload_t(set_data_t)) sr_atr_fdx (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (atr_fdx),
      .changed_o  ()
   );

   ////////////////////////////////////////////////////////////
   // Radio state

   // Receive state lags run_rx by one cycle
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rx_active_o <= 1'b0;
      end else begin
         rx_active_o <= run_rx_i;
      end
   end

   // The magic sample means the transmitter is idle
   assign tx_active   = (sample_tx_i != `MAGIC_TX_OFF);
   assign sample_tx_o = tx_active ? sample_tx_i : '0;

   always_comb begin
      case ({tx_active, rx_active_o})
         2'b00:   gpio_o = atr_idle;
         2'b01:   gpio_o = atr_rx;
         2'b10:   gpio_o = atr_tx;
         default: gpio_o = atr_fdx;
      endcase
   end

   // Pin state for readback
   always_ff @(posedge dsp_clk) begin
      gpio_rb_o <= gpio_i;
   end

endmodule

// ==== hdl/misc_ctrl_regs.sv ====
////////////////////////////////////////////////////////////
// Serdes, ADC and PHY control registers plus the per-bit LED
// source select between hardware status and software.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "radio_ctrl_consts.svh"

module misc_ctrl_regs import radio_ctrl_pkg::*; (
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       run_tx_i,
   input  logic       rx_active_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   output logic [3:0] serdes_ctrl_o,
   output logic [3:0] adc_ctrl_o,
   output logic       phy_resetn_o,
   output ctrl_byte_t leds_o
);

   ctrl_byte_t serdes_reg;
   ctrl_byte_t adc_reg;
   logic       phy_reset;
   ctrl_byte_t led_sw;
   ctrl_byte_t led_src;
   ctrl_byte_t led_hw;

   setting_reg #(.addr(`SR_SERDES), .payload_t(ctrl_byte_t)) sr_serdes (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .out_o(serdes_reg), .changed_o()
   );

   setting_reg #(.addr(`SR_ADC), .payload_t(ctrl_byte_t)) sr_adc (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .out_o(adc_reg), .changed_o()
   );

   setting_reg #(.addr(`SR_PHY), .payload_t(logic)) sr_phy (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .out_o(phy_reset), .changed_o()
   );

   setting_reg #(.addr(`SR_LED_SW), .payload_t(ctrl_byte_t)) sr_led_sw (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .out_o(led_sw), .changed_o()
   );

   // Status LEDs come up under hardware control
   setting_reg #(
      .addr(`SR_LED_SRC), .payload_t(ctrl_byte_t), .at_reset(`LED_SRC_RESET)
   ) sr_led_src (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .out_o(led_src), .changed_o()
   );

   // {enable, prbs, loopback, rx enable}
   assign serdes_ctrl_o = serdes_reg[3:0];
   // {oe a, on a, oe b, on b}
   assign adc_ctrl_o    = adc_reg[3:0];
   assign phy_resetn_o  = ~phy_reset;

   assign led_hw = {3'b000, run_tx_i, rx_active_i, clk_status_i, serdes_link_up_i, 1'b0};

   // Source bit set selects hardware
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// ==== hdl/radio_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types of the radio control block, imported by every
// module that carries bus, time or sample values.
////////////////////////////////////////////////////////////
package radio_ctrl_pkg;

   // Settings bus
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // Seconds and ticks run as one 64-bit VITA time counter
   typedef logic [63:0] vita_time_t;

   // I in the upper half, Q in the lower half
   typedef logic [31:0] sample_t;

   // Payload of the LED, serdes and ADC registers
   typedef logic [7:0]  ctrl_byte_t;

   // Index into the 16 readback words
   typedef logic [3:0]  rb_addr_t;

endpackage

// ==== hdl/radio_ctrl_top.sv ====
////////////////////////////////////////////////////////////
// DSP-clock control block of the radio core. Settings bus in,
// control pins, time and readback out.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module radio_ctrl_top import radio_ctrl_pkg::*; (
   input  logic        dsp_clk,
   input  logic        por_rst,
   // Settings bus
   input  logic        set_stb_i,
   input  set_addr_t   set_addr_i,
   input  set_data_t   set_data_i,
   // Radio status
   input  logic        pps_i,
   input  logic        run_rx_i,
   input  logic        run_tx_i,
   input  sample_t     sample_tx_i,
   input  logic [31:0] gpio_i,
   input  logic        clk_status_i,
   input  logic        serdes_link_up_i,
   input  logic        button_i,
   // Readback
   input  logic        rb_stb_i,
   input  rb_addr_t    rb_addr_i,
   output set_data_t   rb_data_o,
   output logic        rb_valid_o,
   // Control outputs
   output sample_t     sample_tx_o,
   output logic [31:0] gpio_o,
   output logic [3:0]  serdes_ctrl_o,
   output logic [3:0]  adc_ctrl_o,
   output logic        phy_resetn_o,
   output ctrl_byte_t  leds_o,
   output vita_time_t  vita_time_o,
   output logic        pps_int_o
);

   vita_time_t  vita_time_pps;
   logic        rx_active;
   logic [31:0] gpio_rb;

   vita_timer vita_timer0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .pps_i(pps_i), .vita_time_o(vita_time_o),
      .vita_time_pps_o(vita_time_pps), .pps_int_o(pps_int_o)
   );

   atr_gpio atr_gpio0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .run_rx_i(run_rx_i), .sample_tx_i(sample_tx_i), .gpio_i(gpio_i),
      .sample_tx_o(sample_tx_o), .rx_active_o(rx_active),
      .gpio_o(gpio_o), .gpio_rb_o(gpio_rb)
   );

   misc_ctrl_regs misc_regs0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .run_tx_i(run_tx_i), .rx_active_i(rx_active),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .serdes_ctrl_o(serdes_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .phy_resetn_o(phy_resetn_o), .leds_o(leds_o)
   );

   readback_mux rb_mux0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .rb_stb_i(rb_stb_i), .rb_addr_i(rb_addr_i),
      .vita_time_i(vita_time_o), .vita_time_pps_i(vita_time_pps),
      .gpio_rb_i(gpio_rb), .button_i(button_i),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .rb_data_o(rb_data_o), .rb_valid_o(rb_valid_o)
   );

endmodule

// ==== hdl/readback_mux.sv ====
////////////////////////////////////////////////////////////
// Registered 16-word readback. A strobe samples the index and
// the word comes out with a valid pulse on the next cycle.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "radio_ctrl_consts.svh"

module readback_mux import radio_ctrl_pkg::*; (
   input  logic        dsp_clk,
   input  logic        por_rst,
   input  logic        rb_stb_i,
   input  rb_addr_t    rb_addr_i,
   input  vita_time_t  vita_time_i,
   input  vita_time_t  vita_time_pps_i,
   input  logic [31:0] gpio_rb_i,
   input  logic        button_i,
   input  logic        clk_status_i,
   input  logic        serdes_link_up_i,
   output set_data_t   rb_data_o,
   output logic        rb_valid_o
);

   set_data_t irq_word;
   set_data_t rb_word;

   // Bit 12 was the SPI ready flag
   assign irq_word = {18'b0, button_i, 1'b0, clk_status_i, serdes_link_up_i, 10'b0};

   always_comb begin
      case (rb_addr_i)
         `RB_GPIO:    rb_word = gpio_rb_i;
         `RB_TIME_HI: rb_word = vita_time_i[63:32];
         `RB_TIME_LO: rb_word = vita_time_i[31:0];
         `RB_COMPAT:  rb_word = `COMPAT_NUM;
         `RB_IRQ:     rb_word = irq_word;
         `RB_PPS_HI:  rb_word = vita_time_pps_i[63:32];
         `RB_PPS_LO:  rb_word = vita_time_pps_i[31:0];
         default:     rb_word = `RB_UNUSED;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_valid_o <= 1'b0;
      end else begin
         rb_valid_o <= rb_stb_i;
      end
   end

   // Word held until the next strobe
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= rb_word;
      end
   end

endmodule

// ==== hdl/setting_reg.sv ====
////////////////////////////////////////////////////////////
// One register on the settings bus. Loads the low bits of the
// data word when its address is strobed.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module setting_reg import radio_ctrl_pkg::*; #(
   parameter set_addr_t addr = '0,
   parameter type payload_t = logic [31:0],
   parameter payload_t at_reset = '0
) (
   input  logic      dsp_clk,
   input  logic      por_rst,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   output payload_t  out_o,
   output logic      changed_o
);

   localparam int PW = $bits(payload_t);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == addr);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         out_o     <= at_reset;
         changed_o <= 1'b0;
      end else begin
         // Pulse lines up with the cycle the new value shows
         changed_o <= hit;
         if (hit) begin
            out_o <= payload_t'(set_data_i[PW-1:0]);
         end
      end
   end

endmodule

// ==== hdl/vita_timer.sv ====
////////////////////////////////////////////////////////////
// 64-bit VITA time counter. Loaded from the settings bus and
// sampled into a capture register on each PPS rising edge.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "radio_ctrl_consts.svh"

module vita_timer import radio_ctrl_pkg::*; (
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       pps_int_o
);

   set_data_t time_hi;
   set_data_t time_lo;
   logic      time_load;
   logic      pps_meta;
   logic      pps_sync;
   logic      pps_last;
   logic      pps_edge;

   ////////////////////////////////////////////////////////////
   // Load registers

   // High word is only staged here
   setting_reg #(
      .addr      (`SR_TIME_HI),
      .payload_t (set_data_t)
   ) sr_time_hi (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (time_hi),
      .changed_o  ()
   );

   // Writing the low word commits the full 64-bit value
   setting_reg #(
      .addr      (`SR_TIME_LO),
      .payload_t (set_data_t)
   ) sr_time_lo (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .out_o      (time_lo),
      .changed_o  (time_load)
   );

   ////////////////////////////////////////////////////////////
   // Counter

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o <= '0;
      end else if (time_load) begin
         vita_time_o <= {time_hi, time_lo};
      end else begin
         vita_time_o <= vita_time_o + 64'd1;
      end
   end

   ////////////////////////////////////////////////////////////
   // PPS capture

   // Two-flop synchroniser then rising edge detect
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta  <= 1'b0;
         pps_sync  <= 1'b0;
         pps_last  <= 1'b0;
         pps_int_o <= 1'b0;
      end else begin
         pps_meta  <= pps_i;
         pps_sync  <= pps_meta;
         pps_last  <= pps_sync;
         pps_int_o <= pps_edge;
      end
   end

   assign pps_edge = pps_sync & ~pps_last;

   // Captured in the same edge that raises the interrupt
   always_ff @(posedge dsp_clk) begin
      if (pps_edge) begin
         vita_time_pps_o <= vita_time_o;
      end
   end

endmodule

// ==== include/radio_ctrl_consts.svh ====
////////////////////////////////////////////////////////////
// Settings addresses, readback indices and fixed values of the
// radio control block. Include wherever a constant is needed.
////////////////////////////////////////////////////////////
`ifndef RADIO_CTRL_CONSTS_SVH
`define RADIO_CTRL_CONSTS_SVH

// Settings bus base addresses
`define SR_MISC        8'd0
`define SR_TIME64      8'd10
`define SR_GPIO        8'd184

// Misc control registers
`define SR_SERDES      (`SR_MISC + 8'd1)
`define SR_ADC         (`SR_MISC + 8'd2)
`define SR_LED_SW      (`SR_MISC + 8'd3)
`define SR_PHY         (`SR_MISC + 8'd4)
`define SR_LED_SRC     (`SR_MISC + 8'd6)

// High word is staged and the low word commits the time load
`define SR_TIME_HI     (`SR_TIME64 + 8'd0)
`define SR_TIME_LO     (`SR_TIME64 + 8'd1)

// One GPIO word per ATR state
`define SR_ATR_IDLE    (`SR_GPIO + 8'd0)
`define SR_ATR_RX      (`SR_GPIO + 8'd1)
`define SR_ATR_TX      (`SR_GPIO + 8'd2)
`define SR_ATR_FDX     (`SR_GPIO + 8'd3)

// Readback word indices
`define RB_GPIO        4'd9
`define RB_TIME_HI     4'd10
`define RB_TIME_LO     4'd11
`define RB_COMPAT      4'd12
`define RB_IRQ         4'd13
`define RB_PPS_HI      4'd14
`define RB_PPS_LO      4'd15

`define MAGIC_TX_OFF   32'h7fff7fff
`define LED_SRC_RESET  8'b0001_1110
// Major 10, minor 1
`define COMPAT_NUM     32'h000A_0001
`define RB_UNUSED      32'hffff_ffff

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the radio control testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sim.f --top-module tb_radio_ctrl -o sim_radio_ctrl

./obj_dir/sim_radio_ctrl 2>&1 | tee sim.log || true

if grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi
exit 0

// ==== sim.f ====
+incdir+include
hdl/radio_ctrl_pkg.sv
hdl/setting_reg.sv
hdl/vita_timer.sv
hdl/atr_gpio.sv
hdl/misc_ctrl_regs.sv
hdl/readback_mux.sv
hdl/radio_ctrl_top.sv
tb/tb_radio_ctrl.sv

// ==== tb/tb_radio_ctrl.sv ====
////////////////////////////////////////////////////////////
// Testbench for the radio control top level. A reference model
// tracks the settings writes and concurrent assertions check it.
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "radio_ctrl_consts.svh"

module tb_radio_ctrl import radio_ctrl_pkg::*; ();

   logic        dsp_clk;
   logic        por_rst;
   logic        set_stb_i;
   set_addr_t   set_addr_i;
   set_data_t   set_data_i;
   logic        pps_i;
   logic        run_rx_i;
   logic        run_tx_i;
   sample_t     sample_tx_i;
   logic [31:0] gpio_i;
   logic        clk_status_i;
   logic        serdes_link_up_i;
   logic        button_i;
   logic        rb_stb_i;
   rb_addr_t    rb_addr_i;
   set_data_t   rb_data_o;
   logic        rb_valid_o;
   sample_t     sample_tx_o;
   logic [31:0] gpio_o;
   logic [3:0]  serdes_ctrl_o;
   logic [3:0]  adc_ctrl_o;
   logic        phy_resetn_o;
   ctrl_byte_t  leds_o;
   vita_time_t  vita_time_o;
   logic        pps_int_o;

   integer seed = 32'h41de_b7d3;

   // Reference model state
   logic [3:0]  m_serdes;
   logic [3:0]  m_adc;
   logic        m_phy;
   ctrl_byte_t  m_led_sw;
   ctrl_byte_t  m_led_src;
   set_data_t   m_atr_idle;
   set_data_t   m_atr_rx;
   set_data_t   m_atr_tx;
   set_data_t   m_atr_fdx;
   set_data_t   m_time_hi;
   vita_time_t  m_load_val;
   logic        m_load_pend;
   vita_time_t  m_time;
   vita_time_t  m_pps_time;
   logic        m_rx_active;
   logic [31:0] m_gpio_rb;
   logic        m_rb_pend;
   set_data_t   m_rb_exp;

   logic        tx_exp;
   set_data_t   exp_gpio;
   sample_t     exp_sample;
   ctrl_byte_t  led_hw;
   ctrl_byte_t  exp_leds;

   radio_ctrl_top dut0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .pps_i(pps_i), .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .sample_tx_i(sample_tx_i), .gpio_i(gpio_i),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .button_i(button_i), .rb_stb_i(rb_stb_i), .rb_addr_i(rb_addr_i),
      .rb_data_o(rb_data_o), .rb_valid_o(rb_valid_o),
      .sample_tx_o(sample_tx_o), .gpio_o(gpio_o),
      .serdes_ctrl_o(serdes_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .phy_resetn_o(phy_resetn_o), .leds_o(leds_o),
      .vita_time_o(vita_time_o), .pps_int_o(pps_int_o)
   );

   always #5 dsp_clk = ~dsp_clk;

   ////////////////////////////////////////////////////////////
   // Helpers

   task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                  input logic [63:0] act_v);
      $display("SIMULATION FAILED");
      $display("Error at %0t ns: %s expected %h actual %h", $time, name, exp_v, act_v);
      $fatal(1, "stopping at first error");
   endtask

   task automatic report_failure(input string what);
      $display("SIMULATION FAILED");
      $display("At %0t ns: %s", $time, what);
      $fatal(1, "stopping at first error");
   endtask

   function automatic logic [31:0] rand32();
      rand32 = $random(seed);
   endfunction

   task automatic tick();
      @(posedge dsp_clk);
      #1;
   endtask

   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      tick();
      set_stb_i  = 1'b0;
   endtask

   task automatic do_readback(input rb_addr_t idx);
      int waited;
      rb_stb_i  = 1'b1;
      rb_addr_i = idx;
      tick();
      rb_stb_i  = 1'b0;
      waited    = 0;
      while (!rb_valid_o) begin
         if (waited == 8) begin
            report_failure("rb_valid_o never rose after a readback strobe");
         end else begin
            tick();
            waited++;
         end
      end
      tick();
   endtask

   task automatic pulse_pps();
      int waited;
      pps_i  = 1'b1;
      waited = 0;
      while (!pps_int_o) begin
         if (waited == 10) begin
            report_failure("pps_int_o never rose after a pulse on pps_i");
         end else begin
            tick();
            waited++;
         end
      end
      pps_i = 1'b0;
      repeat (4) tick();
   endtask

   // Readback word as it stood in the strobe cycle
   function automatic set_data_t expected_rb(input rb_addr_t idx);
      vita_time_t pps_now;
      set_data_t  irq;
      pps_now  = pps_int_o ? (m_time - 64'd1) : m_pps_time;
      irq      = '0;
      irq[13]  = button_i;
      irq[11]  = clk_status_i;
      irq[10]  = serdes_link_up_i;
      case (idx)
         `RB_GPIO:    expected_rb = m_gpio_rb;
         `RB_TIME_HI: expected_rb = m_time[63:32];
         `RB_TIME_LO: expected_rb = m_time[31:0];
         `RB_COMPAT:  expected_rb = `COMPAT_NUM;
         `RB_IRQ:     expected_rb = irq;
         `RB_PPS_HI:  expected_rb = pps_now[63:32];
         `RB_PPS_LO:  expected_rb = pps_now[31:0];
         default:     expected_rb = `RB_UNUSED;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Reference model

   always @(posedge dsp_clk) begin
      m_gpio_rb <= gpio_i;
      if (pps_int_o) begin
         m_pps_time <= m_time - 64'd1;
      end
      if (por_rst) begin
         m_serdes    <= '0;
         m_adc       <= '0;
         m_phy       <= 1'b0;
         m_led_sw    <= '0;
         m_led_src   <= `LED_SRC_RESET;
         m_atr_idle  <= '0;
         m_atr_rx    <= '0;
         m_atr_tx    <= '0;
         m_atr_fdx   <= '0;
         m_time_hi   <= '0;
         m_load_pend <= 1'b0;
         m_time      <= '0;
         m_rx_active <= 1'b0;
         m_rb_pend   <= 1'b0;
      end else begin
         m_rx_active <= run_rx_i;
         m_rb_pend   <= rb_stb_i;
         if (rb_stb_i) begin
            m_rb_exp <= expected_rb(rb_addr_i);
         end
         // Low word write commits one cycle after its register loads
         m_time      <= m_load_pend ? m_load_val : (m_time + 64'd1);
         m_load_pend <= set_stb_i && (set_addr_i == `SR_TIME_LO);
         if (set_stb_i) begin
            case (set_addr_i)
               `SR_SERDES:   m_serdes   <= set_data_i[3:0];
               `SR_ADC:      m_adc      <= set_data_i[3:0];
               `SR_PHY:      m_phy      <= set_data_i[0];
               `SR_LED_SW:   m_led_sw   <= set_data_i[7:0];
               `SR_LED_SRC:  m_led_src  <= set_data_i[7:0];
               `SR_TIME_HI:  m_time_hi  <= set_data_i;
               `SR_TIME_LO:  m_load_val <= {m_time_hi, set_data_i};
               `SR_ATR_IDLE: m_atr_idle <= set_data_i;
               `SR_ATR_RX:   m_atr_rx   <= set_data_i;
               `SR_ATR_TX:   m_atr_tx   <= set_data_i;
               `SR_ATR_FDX:  m_atr_fdx  <= set_data_i;
               default:      ;
            endcase
         end
      end
   end

   assign tx_exp     = (sample_tx_i != `MAGIC_TX_OFF);
   assign exp_sample = tx_exp ? sample_tx_i : 32'h0;
   assign exp_gpio   = tx_exp ? (m_rx_active ? m_atr_fdx : m_atr_tx)
                              : (m_rx_active ? m_atr_rx : m_atr_idle);
   assign led_hw     = {3'b000, run_tx_i, m_rx_active, clk_status_i, serdes_link_up_i, 1'b0};

   always_comb begin
      for (int b = 0; b < 8; b++) begin
         exp_leds[b] = m_led_src[b] ? led_hw[b] : m_led_sw[b];
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks sampled on the falling edge where all is settled

   a_serdes: assert property (@(negedge dsp_clk) serdes_ctrl_o == m_serdes)
      else report_mismatch("serdes_ctrl_o", 64'(m_serdes), 64'(serdes_ctrl_o));
   a_adc: assert property (@(negedge dsp_clk) adc_ctrl_o == m_adc)
      else report_mismatch("adc_ctrl_o", 64'(m_adc), 64'(adc_ctrl_o));
   a_phy: assert property (@(negedge dsp_clk) phy_resetn_o == !m_phy)
      else report_mismatch("phy_resetn_o", 64'(!m_phy), 64'(phy_resetn_o));
   a_leds: assert property (@(negedge dsp_clk) leds_o == exp_leds)
      else report_mismatch("leds_o", 64'(exp_leds), 64'(leds_o));
   a_time: assert property (@(negedge dsp_clk) vita_time_o == m_time)
      else report_mismatch("vita_time_o", m_time, vita_time_o);
   a_gpio: assert property (@(negedge dsp_clk) gpio_o == exp_gpio)
      else report_mismatch("gpio_o", 64'(exp_gpio), 64'(gpio_o));
   a_sample: assert property (@(negedge dsp_clk) sample_tx_o == exp_sample)
      else report_mismatch("sample_tx_o", 64'(exp_sample), 64'(sample_tx_o));
   a_pps_rst: assert property (@(negedge dsp_clk) por_rst |-> !pps_int_o)
      else report_mismatch("pps_int_o", 64'(0), 64'(pps_int_o));
   a_pps_width: assert property (@(negedge dsp_clk) !(pps_int_o && $past(pps_int_o)))
      else report_mismatch("pps_int_o", 64'(0), 64'(pps_int_o));
   a_pps_time: assert property (@(negedge dsp_clk)
                                pps_int_o |-> dut0.vita_time_pps == m_time - 64'd1)
      else report_mismatch("vita_time_pps", m_time - 64'd1, dut0.vita_time_pps);
   a_rb_valid: assert property (@(negedge dsp_clk) rb_valid_o == m_rb_pend)
      else report_mismatch("rb_valid_o", 64'(m_rb_pend), 64'(rb_valid_o));
   a_rb_data: assert property (@(negedge dsp_clk) rb_valid_o |-> rb_data_o == m_rb_exp)
      else report_mismatch("rb_data_o", 64'(m_rb_exp), 64'(rb_data_o));

   ////////////////////////////////////////////////////////////
   // Stimulus

   initial begin
      logic [31:0] r;
      dsp_clk          = 1'b0;
      por_rst          = 1'b1;
      set_stb_i        = 1'b0;
      set_addr_i       = '0;
      set_data_i       = '0;
      pps_i            = 1'b0;
      run_rx_i         = 1'b0;
      run_tx_i         = 1'b0;
      sample_tx_i      = `MAGIC_TX_OFF;
      gpio_i           = '0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      button_i         = 1'b0;
      rb_stb_i         = 1'b0;
      rb_addr_i        = '0;

      repeat (5) @(posedge dsp_clk);
      #1 por_rst = 1'b0;
      repeat (10) tick();

      // Control registers mixed with unmapped writes
      for (int i = 0; i < 40; i++) begin
         r = rand32();
         case (r[1:0])
            2'd0:    write_setting(`SR_SERDES, rand32());
            2'd1:    write_setting(`SR_ADC, rand32());
            2'd2:    write_setting(`SR_PHY, rand32());
            default: write_setting(8'd20 + {1'b0, r[8:2]}, rand32());
         endcase
         if (r[9]) begin
            tick();
         end
      end

      // LED source select against random hardware status
      for (int i = 0; i < 8; i++) begin
         write_setting(`SR_LED_SW, rand32());
         write_setting(`SR_LED_SRC, rand32());
         for (int j = 0; j < 8; j++) begin
            r = rand32();
            run_tx_i         = r[0];
            run_rx_i         = r[1];
            clk_status_i     = r[2];
            serdes_link_up_i = r[3];
            tick();
         end
      end

      // Time load across a low word carry then PPS captures
      write_setting(`SR_TIME_HI, rand32());
      write_setting(`SR_TIME_LO, 32'hffff_fff8);
      repeat (12) tick();
      pulse_pps();
      write_setting(`SR_TIME_HI, rand32());
      write_setting(`SR_TIME_LO, rand32());
      repeat (3) tick();
      pulse_pps();

      // ATR words and sample gating
      write_setting(`SR_ATR_IDLE, rand32());
      write_setting(`SR_ATR_RX, rand32());
      write_setting(`SR_ATR_TX, rand32());
      write_setting(`SR_ATR_FDX, rand32());
      for (int i = 0; i < 32; i++) begin
         r = rand32();
         run_rx_i    = r[0];
         sample_tx_i = (i % 3 == 0) ? `MAGIC_TX_OFF : rand32();
         tick();
      end

      // Single readbacks of every index
      for (int i = 0; i < 16; i++) begin
         r = rand32();
         gpio_i           = rand32();
         button_i         = r[0];
         clk_status_i     = r[1];
         serdes_link_up_i = r[2];
         tick();
         do_readback(4'(i));
      end

      // Back to back strobes with one valid per cycle
      rb_stb_i = 1'b1;
      for (int i = 0; i < 16; i++) begin
         r = rand32();
         rb_addr_i = r[3:0];
         gpio_i    = rand32();
         button_i  = r[4];
         tick();
      end
      rb_stb_i = 1'b0;
      repeat (4) tick();

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule
